/* flist.f */
+incdir+design
design/tlc_pkg.sv
design/road_pkg.sv
design/tlc_wb_regs.sv
design/tlc_phase_ctrl.sv
design/car_lane.sv
design/violation_log.sv
design/tlc_top.sv
testbench/tb_tlc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tlc
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_tlc.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module tb_tlc;
    import tlc_pkg::*;
    import road_pkg::*;

    typedef logic [`WB_ADR_W-1:0] adr_t;

    typedef struct packed {
        logic [1:0] lane;
        logic [7:0] steps;
        logic       red;
        logic [9:0] pos;
        logic [3:0] viol;
    } lane_row_t;

    localparam adr_t adr_ctrl   = 'd0;
    localparam adr_t adr_cmd    = 'd1;
    localparam adr_t adr_status = 'd2;
    localparam adr_t adr_count  = 'd3;
    localparam int   bus_limit  = 16;

    // lamp codes are {red, yellow, green}
    localparam logic [2:0] exp_red    = 3'b100;
    localparam logic [2:0] exp_yellow = 3'b010;
    localparam logic [2:0] exp_green  = 3'b001;
    localparam logic [2:0] exp_dark   = 3'b000;

    logic        CLOCK_50;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    adr_t        wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] seed   = 32'ha442_70f3;

    // lane, steps, red on, expected position, expected mask bits
    // stop line is crossed on the step from 160 to 168, 480 wraps to 0
    // green rows step an NS lane while NS green is held
    lane_row_t lane_table [5] = '{
        '{2'd0, 8'd25, 1'b1, 10'd200, 4'b0001},
        '{2'd1, 8'd25, 1'b0, 10'd200, 4'b0000},
        '{2'd2, 8'd62, 1'b1, 10'd16,  4'b0100},
        '{2'd3, 8'd15, 1'b1, 10'd120, 4'b0000},
        '{2'd3, 8'd8,  1'b1, 10'd184, 4'b1000}
    };

    tlc_top dut_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    // bus cycles start and end 1 ns after a rising edge
    task automatic write_reg(input adr_t adr, input wb_data_t data);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end while (!wb_ack && n < bus_limit);
        if (!wb_ack) begin
            errors++;
            $display("bus write to address %0d was never acknowledged", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_reg(input adr_t adr, output wb_data_t data);
        int n;
        n      = 0;
        data   = '0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end while (!wb_ack && n < bus_limit);
        if (!wb_ack) begin
            errors++;
            $display("bus read from address %0d was never acknowledged", adr);
        end else begin
            data = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_log(input logic [3:0] exp_mask, input int exp_count);
        wb_data_t rd;
        read_reg(adr_status, rd);
        compare("viol_mask", 32'(exp_mask), 32'(rd[15:12]));
        read_reg(adr_count, rd);
        compare("viol_count", 32'(exp_count), 32'(rd[23:16]));
    endtask

    // ==============================
    // behaviors
    // ==============================
    task automatic check_reset();
        wb_data_t rd;
        read_reg(adr_count, rd);
        compare("secs_ns", 32'(`TLC_GREEN_SEC), 32'(rd[7:0]));
        compare("secs_ew", 32'd0, 32'(rd[15:8]));
        compare("viol_count", 32'd0, 32'(rd[23:16]));
        read_reg(adr_status, rd);
        compare("lamp_ns", 32'(exp_green), 32'(rd[2:0]));
        compare("lamp_ew", 32'(exp_red), 32'(rd[5:3]));
        compare("phase", 32'd0, 32'(rd[8:6]));
        compare("viol_mask", 32'd0, 32'(rd[15:12]));
        for (int i = 0; i < `NUM_LANES; i++) begin
            read_reg(adr_t'(4 + i), rd);
            compare($sformatf("lane_pos[%0d]", i), 32'd0, 32'(rd[9:0]));
        end
    endtask

    task automatic run_fixed();
        wb_data_t st;
        wb_data_t cnt;
        int       cur;
        int       seen;
        int       polls;
        write_reg(adr_ctrl, 32'h0);
        read_reg(adr_status, st);
        cur   = int'(st[8:6]);
        seen  = 0;
        polls = 0;
        // one full cycle of six phases, ending back at NS green
        while (seen < 6 && polls < 300) begin
            read_reg(adr_status, st);
            read_reg(adr_count, cnt);
            polls++;
            if (int'(st[8:6]) != cur) begin
                compare("phase", 32'((cur + 1) % 6), 32'(st[8:6]));
                cur = int'(st[8:6]);
                seen++;
            end
            if (cnt[7:0] > `TLC_GREEN_SEC) begin
                compare("secs_ns", 32'(`TLC_GREEN_SEC), 32'(cnt[7:0]));
            end
            if (st[8:6] < 3'd2) begin
                compare("secs_ew", 32'd0, 32'(cnt[15:8]));
            end
        end
        if (seen < 6) begin
            errors++;
            $display("fixed mode did not complete a phase cycle in time");
        end else begin
            compare("phase", 32'd0, 32'(cur));
        end
    endtask

    task automatic run_actuated();
        wb_data_t st;
        int       polls;
        write_reg(adr_ctrl, 32'h1);
        read_reg(adr_ctrl, st);
        compare("ctrl", 32'h1, 32'(st[3:0]));
        // twice the green time without demand from EW
        for (int i = 0; i < `TLC_GREEN_SEC * `TLC_TICKS_PER_SEC; i++) begin
            read_reg(adr_status, st);
            compare("phase", 32'd0, 32'(st[8:6]));
        end
        read_reg(adr_count, st);
        compare("secs_ns", 32'd1, 32'(st[7:0]));
        write_reg(adr_cmd, 32'h2);
        polls = 0;
        do begin
            read_reg(adr_status, st);
            polls++;
        end while (st[8:6] != 3'd3 && polls < 100);
        if (st[8:6] != 3'd3) begin
            errors++;
            $display("actuated mode never reached EW green after the EW request");
        end
    endtask

    task automatic run_lock_night();
        wb_data_t st;
        int       polls;
        logic     seen_on;
        logic     seen_off;
        write_reg(adr_ctrl, 32'h3);
        read_reg(adr_status, st);
        compare("lamp_ns", 32'(exp_red), 32'(st[2:0]));
        compare("lamp_ew", 32'(exp_red), 32'(st[5:3]));
        read_reg(adr_count, st);
        compare("secs_ns", 32'd0, 32'(st[7:0]));
        compare("secs_ew", 32'd0, 32'(st[15:8]));
        write_reg(adr_ctrl, 32'h2);
        seen_on  = 1'b0;
        seen_off = 1'b0;
        polls    = 0;
        while (!(seen_on && seen_off) && polls < 40) begin
            read_reg(adr_status, st);
            polls++;
            if (st[2:0] == exp_yellow) seen_on = 1'b1;
            else if (st[2:0] == exp_dark) seen_off = 1'b1;
            else compare("lamp_ns", 32'(exp_yellow), 32'(st[2:0]));
            if (st[5:3] != exp_yellow && st[5:3] != exp_dark) begin
                compare("lamp_ew", 32'(exp_yellow), 32'(st[5:3]));
            end
        end
        if (!(seen_on && seen_off)) begin
            errors++;
            $display("night mode yellow did not toggle in time");
        end
        read_reg(adr_count, st);
        compare("secs_ns", 32'd0, 32'(st[7:0]));
        compare("secs_ew", 32'd0, 32'(st[15:8]));
    endtask

    // lock gives red on every lane, actuated mode with no demand holds NS green
    task automatic apply_row(input lane_row_t row, inout logic [3:0] exp_mask,
                             inout int exp_count);
        wb_data_t rd;
        write_reg(adr_ctrl, row.red ? 32'h3 : 32'h1);
        for (int k = 0; k < int'(row.steps); k++) begin
            write_reg(adr_cmd, 32'(1) << (2 + int'(row.lane)));
        end
        idle(2);
        exp_mask  = exp_mask | row.viol;
        exp_count = exp_count + $countones(row.viol);
        read_reg(adr_t'(4 + int'(row.lane)), rd);
        compare($sformatf("lane_pos[%0d]", row.lane), 32'(row.pos), 32'(rd[9:0]));
        check_log(exp_mask, exp_count);
    endtask

    task automatic run_lanes();
        int         order [4];
        int         j;
        int         tmp;
        logic [3:0] exp_mask;
        int         exp_count;
        exp_mask  = '0;
        exp_count = 0;
        for (int i = 0; i < 4; i++) order[i] = i;
        for (int i = 3; i > 0; i--) begin
            seed     = lcg_next(seed);
            j        = int'(seed[31:16]) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            apply_row(lane_table[order[i]], exp_mask, exp_count);
        end
        write_reg(adr_cmd, 32'h40);
        idle(2);
        exp_mask  = '0;
        exp_count = 0;
        check_log(exp_mask, exp_count);
        apply_row(lane_table[4], exp_mask, exp_count);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (2) @(posedge CLOCK_50);
        #1;
        rst_n = 1'b1;
        check_reset();
        run_fixed();
        run_actuated();
        run_lock_night();
        run_lanes();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* design/tlc_top.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module tlc_top (
    input  logic                 CLOCK_50,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  tlc_pkg::wb_data_t    wb_dat_w,
    output tlc_pkg::wb_data_t    wb_dat_r,
    output logic                 wb_ack
);
    import tlc_pkg::*;
    import road_pkg::*;

    mode_t      mode;
    logic       veh_ns_level;
    logic       veh_ew_level;
    logic       veh_ns_pulse;
    logic       veh_ew_pulse;
    lane_mask_t step;
    logic       viol_clear;
    lamp_t      lamp_ns;
    lamp_t      lamp_ew;
    phase_t     phase;
    secs_t      secs_ns;
    secs_t      secs_ew;
    logic       red_ns;
    logic       red_ew;
    lane_mask_t viol_events;
    lane_mask_t viol_mask;
    viol_cnt_t  viol_count;
    pos_t       lane_pos [`NUM_LANES];

    // ==============================
    // host port and controller
    // ==============================
    tlc_wb_regs u_regs (
        .CLOCK_50     (CLOCK_50),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .mode         (mode),
        .veh_ns_level (veh_ns_level),
        .veh_ew_level (veh_ew_level),
        .veh_ns_pulse (veh_ns_pulse),
        .veh_ew_pulse (veh_ew_pulse),
        .step         (step),
        .viol_clear   (viol_clear),
        .lamp_ns      (lamp_ns),
        .lamp_ew      (lamp_ew),
        .phase        (phase),
        .secs_ns      (secs_ns),
        .secs_ew      (secs_ew),
        .viol_mask    (viol_mask),
        .viol_count   (viol_count),
        .lane_pos     (lane_pos)
    );

    tlc_phase_ctrl u_ctrl (
        .CLOCK_50     (CLOCK_50),
        .rst_n        (rst_n),
        .mode         (mode),
        .veh_ns_level (veh_ns_level),
        .veh_ew_level (veh_ew_level),
        .veh_ns_pulse (veh_ns_pulse),
        .veh_ew_pulse (veh_ew_pulse),
        .lamp_ns      (lamp_ns),
        .lamp_ew      (lamp_ew),
        .phase        (phase),
        .secs_ns      (secs_ns),
        .secs_ew      (secs_ew),
        .red_ns       (red_ns),
        .red_ew       (red_ew)
    );

    // ==============================
    // lanes
    // ==============================
    // north and south watch the NS red, west and east the EW red
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        car_lane u_lane (
            .CLOCK_50   (CLOCK_50),
            .rst_n      (rst_n),
            .step       (step[i]),
            .red        ((i < 2) ? red_ns : red_ew),
            .pos        (lane_pos[i]),
            .viol_event (viol_events[i])
        );
    end

    violation_log u_log (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .events   (viol_events),
        .clear    (viol_clear),
        .mask     (viol_mask),
        .count    (viol_count)
    );

endmodule

/* design/violation_log.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module violation_log (
    input  logic                 CLOCK_50,
    input  logic                 rst_n,
    input  road_pkg::lane_mask_t events,
    input  logic                 clear,
    output road_pkg::lane_mask_t mask,
    output road_pkg::viol_cnt_t  count
);
    import road_pkg::*;

    // one spare bit to catch overflow
    logic [$bits(viol_cnt_t):0] sum;

    always_comb begin
        sum = {1'b0, count};
        for (int i = 0; i < `NUM_LANES; i++) begin
            sum = sum + events[i];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            mask  <= '0;
            count <= '0;
        end else if (clear) begin
            mask  <= '0;
            count <= '0;
        end else begin
            mask  <= mask | events;
            count <= sum[$bits(viol_cnt_t)] ? '1 : viol_cnt_t'(sum);
        end
    end

endmodule

/* design/car_lane.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module car_lane (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    input  logic           step,
    input  logic           red,
    output road_pkg::pos_t pos,
    output logic           viol_event
);
    import road_pkg::*;

    localparam pos_t step_dist = pos_t'(`CAR_STEP);
    localparam pos_t lane_len  = pos_t'(`LANE_LENGTH);
    localparam pos_t stop_line = pos_t'(`STOP_LINE);
    localparam pos_t car_len   = pos_t'(`CAR_LEN);

    pos_t pos_nxt;
    logic wraps;
    logic front_before;
    logic front_after;

    assign pos_nxt = pos + step_dist;
    assign wraps   = (pos_nxt >= lane_len);

    // car front relative to the stop line, before and after the step
    assign front_before = ((pos + car_len) <= stop_line);
    assign front_after  = ((pos_nxt + car_len) > stop_line);

    // ==============================
    // position and crossing check
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            pos        <= '0;
            viol_event <= 1'b0;
        end else begin
            viol_event <= 1'b0;
            if (step) begin
                if (wraps) begin
                    // back to the entry point, nothing crossed
                    pos <= '0;
                end else begin
                    pos        <= pos_nxt;
                    viol_event <= red && front_before && front_after;
                end
            end
        end
    end

endmodule

/* design/tlc_phase_ctrl.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module tlc_phase_ctrl (
    input  logic            CLOCK_50,
    input  logic            rst_n,
    input  tlc_pkg::mode_t  mode,
    input  logic            veh_ns_level,
    input  logic            veh_ew_level,
    input  logic            veh_ns_pulse,
    input  logic            veh_ew_pulse,
    output tlc_pkg::lamp_t  lamp_ns,
    output tlc_pkg::lamp_t  lamp_ew,
    output tlc_pkg::phase_t phase,
    output tlc_pkg::secs_t  secs_ns,
    output tlc_pkg::secs_t  secs_ew,
    output logic            red_ns,
    output logic            red_ew
);
    import tlc_pkg::*;

    localparam int tick_w = $clog2(`TLC_TICKS_PER_SEC);
    localparam logic [tick_w-1:0] tick_last = tick_w'(`TLC_TICKS_PER_SEC - 1);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;
    logic              req_ns;
    logic              req_ew;
    logic              hold;
    logic              flash;
    logic              running;
    secs_t             secs_left;
    phase_t            phase_nxt;

    // ==============================
    // seconds tick
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = (tick_cnt == tick_last);

    // request latches, only kept in actuated mode
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            req_ns <= 1'b0;
            req_ew <= 1'b0;
        end else if (mode == mode_act) begin
            if (veh_ns_pulse) req_ns <= 1'b1;
            else if (phase == ph_ns_green) req_ns <= 1'b0;
            if (veh_ew_pulse) req_ew <= 1'b1;
            else if (phase == ph_ew_green) req_ew <= 1'b0;
        end else begin
            req_ns <= 1'b0;
            req_ew <= 1'b0;
        end
    end

    // green stays while the other road has no demand
    assign hold = (mode == mode_act) &&
                  ((phase == ph_ns_green && !(veh_ew_level || req_ew)) ||
                   (phase == ph_ew_green && !(veh_ns_level || req_ns)));

    assign running = (mode == mode_fixed) || (mode == mode_act);

    // ==============================
    // phase machine
    // ==============================
    always_comb begin
        case (phase)
            ph_ns_green:  phase_nxt = ph_ns_yellow;
            ph_ns_yellow: phase_nxt = ph_all_red_1;
            ph_all_red_1: phase_nxt = ph_ew_green;
            ph_ew_green:  phase_nxt = ph_ew_yellow;
            ph_ew_yellow: phase_nxt = ph_all_red_2;
            default:      phase_nxt = ph_ns_green;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ph_ns_green;
            secs_left <= phase_secs(ph_ns_green);
        end else if (!running) begin
            // night and lock restart the cycle from NS green
            phase     <= ph_ns_green;
            secs_left <= phase_secs(ph_ns_green);
        end else if (tick) begin
            if (secs_left > secs_t'(1)) begin
                secs_left <= secs_left - 1'b1;
            end else if (!hold) begin
                phase     <= phase_nxt;
                secs_left <= phase_secs(phase_nxt);
            end
        end
    end

    // night flash, starts lit
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            flash <= 1'b1;
        end else if (mode != mode_night) begin
            flash <= 1'b1;
        end else if (tick) begin
            flash <= ~flash;
        end
    end

    // ==============================
    // lamps and split countdown
    // ==============================
    always_comb begin
        lamp_ns = lamp_red;
        lamp_ew = lamp_red;
        secs_ns = '0;
        secs_ew = '0;
        if (mode == mode_night) begin
            lamp_ns = flash ? lamp_yellow : lamp_off;
            lamp_ew = flash ? lamp_yellow : lamp_off;
        end else if (running) begin
            case (phase)
                ph_ns_green: begin
                    lamp_ns = lamp_green;
                    secs_ns = secs_left;
                end
                ph_ns_yellow: begin
                    lamp_ns = lamp_yellow;
                    secs_ns = secs_left;
                end
                ph_ew_green: begin
                    lamp_ew = lamp_green;
                    secs_ew = secs_left;
                end
                ph_ew_yellow: begin
                    lamp_ew = lamp_yellow;
                    secs_ew = secs_left;
                end
                default: begin
                    lamp_ns = lamp_red;
                    lamp_ew = lamp_red;
                end
            endcase
        end
    end

    assign red_ns = lamp_ns[2];
    assign red_ew = lamp_ew[2];

endmodule

/* design/tlc_wb_regs.sv */
`timescale 1ns/1ps
`include "tlc_settings.svh"

module tlc_wb_regs (
    input  logic                 CLOCK_50,
    input  logic                 rst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`WB_ADR_W-1:0] wb_adr,
    input  tlc_pkg::wb_data_t    wb_dat_w,
    output tlc_pkg::wb_data_t    wb_dat_r,
    output logic                 wb_ack,
    output tlc_pkg::mode_t       mode,
    output logic                 veh_ns_level,
    output logic                 veh_ew_level,
    output logic                 veh_ns_pulse,
    output logic                 veh_ew_pulse,
    output road_pkg::lane_mask_t step,
    output logic                 viol_clear,
    input  tlc_pkg::lamp_t       lamp_ns,
    input  tlc_pkg::lamp_t       lamp_ew,
    input  tlc_pkg::phase_t      phase,
    input  tlc_pkg::secs_t       secs_ns,
    input  tlc_pkg::secs_t       secs_ew,
    input  road_pkg::lane_mask_t viol_mask,
    input  road_pkg::viol_cnt_t  viol_count,
    input  road_pkg::pos_t       lane_pos [`NUM_LANES]
);
    import tlc_pkg::*;
    import road_pkg::*;

    localparam logic [`WB_ADR_W-1:0] adr_ctrl   = 'd0;
    localparam logic [`WB_ADR_W-1:0] adr_cmd    = 'd1;
    localparam logic [`WB_ADR_W-1:0] adr_status = 'd2;
    localparam logic [`WB_ADR_W-1:0] adr_count  = 'd3;

    logic wr_stb;

    // strobe seen while ack is still low
    assign wr_stb = wb_cyc && wb_stb && !wb_ack && wb_we;

    // ==============================
    // handshake
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // CTRL register
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode         <= mode_fixed;
            veh_ns_level <= 1'b0;
            veh_ew_level <= 1'b0;
        end else if (wr_stb && wb_adr == adr_ctrl) begin
            mode         <= mode_t'(wb_dat_w[1:0]);
            veh_ns_level <= wb_dat_w[2];
            veh_ew_level <= wb_dat_w[3];
        end
    end

    // CMD pulses, high for the ack cycle only
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            veh_ns_pulse <= 1'b0;
            veh_ew_pulse <= 1'b0;
            step         <= '0;
            viol_clear   <= 1'b0;
        end else if (wr_stb && wb_adr == adr_cmd) begin
            veh_ns_pulse <= wb_dat_w[0];
            veh_ew_pulse <= wb_dat_w[1];
            step         <= wb_dat_w[2 +: `NUM_LANES];
            viol_clear   <= wb_dat_w[6];
        end else begin
            veh_ns_pulse <= 1'b0;
            veh_ew_pulse <= 1'b0;
            step         <= '0;
            viol_clear   <= 1'b0;
        end
    end

    // ==============================
    // read mux
    // ==============================
    // address is held by the master until ack, so live state is returned
    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            adr_ctrl: begin
                wb_dat_r[3:0] = {veh_ew_level, veh_ns_level, mode};
            end
            adr_status: begin
                wb_dat_r[2:0]             = lamp_ns;
                wb_dat_r[5:3]             = lamp_ew;
                wb_dat_r[8:6]             = phase;
                wb_dat_r[12 +: `NUM_LANES] = viol_mask;
            end
            adr_count: begin
                wb_dat_r[7:0]   = secs_ns;
                wb_dat_r[15:8]  = secs_ew;
                wb_dat_r[23:16] = viol_count;
            end
            default: begin
                // lane positions at 4 to 7, CMD reads back as zero
                if (wb_adr[2]) begin
                    wb_dat_r[$bits(pos_t)-1:0] = lane_pos[wb_adr[1:0]];
                end
            end
        endcase
    end

endmodule

/* design/road_pkg.sv */
`include "tlc_settings.svh"

package road_pkg;

    // distance travelled from the lane entry point
    typedef logic [9:0] pos_t;

    // lane order in every mask: bit 0 north, 1 south, 2 west, 3 east
    typedef logic [`NUM_LANES-1:0] lane_mask_t;

    // saturates at 255
    typedef logic [7:0] viol_cnt_t;

endpackage

/* design/tlc_pkg.sv */
`include "tlc_settings.svh"

package tlc_pkg;

    typedef enum logic [1:0] {
        mode_fixed,
        mode_act,
        mode_night,
        mode_lock
    } mode_t;

    typedef enum logic [2:0] {
        ph_ns_green  = 3'd0,
        ph_ns_yellow = 3'd1,
        ph_all_red_1 = 3'd2,
        ph_ew_green  = 3'd3,
        ph_ew_yellow = 3'd4,
        ph_all_red_2 = 3'd5
    } phase_t;

    // {red, yellow, green}
    typedef logic [2:0]  lamp_t;
    typedef logic [7:0]  secs_t;
    typedef logic [31:0] wb_data_t;

    localparam lamp_t lamp_off    = 3'b000;
    localparam lamp_t lamp_red    = 3'b100;
    localparam lamp_t lamp_yellow = 3'b010;
    localparam lamp_t lamp_green  = 3'b001;

    // starting value of the countdown for each phase
    function automatic secs_t phase_secs(phase_t ph);
        case (ph)
            ph_ns_green, ph_ew_green:   return secs_t'(`TLC_GREEN_SEC);
            ph_ns_yellow, ph_ew_yellow: return secs_t'(`TLC_YELLOW_SEC);
            default:                    return secs_t'(`TLC_ALLRED_SEC);
        endcase
    endfunction

endpackage

/* design/tlc_settings.svh */
`ifndef TLC_SETTINGS_SVH
`define TLC_SETTINGS_SVH

// ==============================
// controller timing
// ==============================

// clock cycles per controller second, kept small for simulation
`define TLC_TICKS_PER_SEC 8

// phase durations in seconds
`define TLC_GREEN_SEC  5
`define TLC_YELLOW_SEC 2
`define TLC_ALLRED_SEC 1

// ==============================
// lane geometry
// ==============================

// a step reaching the lane length wraps the car back to 0
`define LANE_LENGTH 480
`define STOP_LINE   180
`define CAR_STEP    8
`define CAR_LEN     20
`define NUM_LANES   4

// ==============================
// bus
// ==============================
`define WB_ADR_W 3

`endif
